//--- design/id_pkg.sv
`default_nettype none

package id_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [9:0]  alu_op_t;
    typedef logic [2:0]  branch_kind_t;

    // Bit positions in the one-hot ALU selector
    localparam int ALU_ADD   = 0;
    localparam int ALU_SUB   = 1;
    localparam int ALU_SLT   = 2;
    localparam int ALU_SLTU  = 3;
    localparam int ALU_AND   = 4;
    localparam int ALU_NOR   = 5;
    localparam int ALU_OR    = 6;
    localparam int ALU_XOR   = 7;
    localparam int ALU_LUI   = 8;
    localparam int ALU_SPARE = 9;

    // Branch kinds
    localparam branch_kind_t BR_NONE   = 3'd0;
    localparam branch_kind_t BR_BEQ    = 3'd1;
    localparam branch_kind_t BR_BNE    = 3'd2;
    localparam branch_kind_t BR_BLT    = 3'd3;
    localparam branch_kind_t BR_BGE    = 3'd4;
    localparam branch_kind_t BR_UNCOND = 3'd5;
    localparam branch_kind_t BR_JIRL   = 3'd6;

    // Major opcode in bits 31:26
    localparam logic [5:0] OP_HI_ALU3R = 6'h00;
    localparam logic [5:0] OP_HI_LU12I = 6'h05;
    localparam logic [5:0] OP_HI_LDST  = 6'h0a;
    localparam logic [5:0] OP_HI_JIRL  = 6'h13;
    localparam logic [5:0] OP_HI_B     = 6'h14;
    localparam logic [5:0] OP_HI_BL    = 6'h15;
    localparam logic [5:0] OP_HI_BEQ   = 6'h16;
    localparam logic [5:0] OP_HI_BNE   = 6'h17;
    localparam logic [5:0] OP_HI_BLT   = 6'h18;
    localparam logic [5:0] OP_HI_BGE   = 6'h19;

    // Bits 25:22
    localparam logic [3:0] OP_MID_ALU3R = 4'h0;
    localparam logic [3:0] OP_MID_LDW   = 4'h2;
    localparam logic [3:0] OP_MID_STW   = 4'h6;
    localparam logic [3:0] OP_MID_ADDI  = 4'ha;
    localparam logic [3:0] OP_MID_ANDI  = 4'hd;
    localparam logic [3:0] OP_MID_ORI   = 4'he;

    // Bits 21:20 of the three-register group
    localparam logic [1:0] OP_SUB_3R = 2'h1;

    // Bits 19:15
    localparam logic [4:0] OP_LO_ADD  = 5'h00;
    localparam logic [4:0] OP_LO_SUB  = 5'h02;
    localparam logic [4:0] OP_LO_SLT  = 5'h04;
    localparam logic [4:0] OP_LO_SLTU = 5'h05;
    localparam logic [4:0] OP_LO_NOR  = 5'h08;
    localparam logic [4:0] OP_LO_AND  = 5'h09;
    localparam logic [4:0] OP_LO_OR   = 5'h0a;
    localparam logic [4:0] OP_LO_XOR  = 5'h0b;

    // Link register for bl
    localparam reg_addr_t RA_REG = 5'd1;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_bundle_t;

    typedef struct packed {
        alu_op_t      alu_op;
        logic         src1_is_pc;
        logic         src2_is_imm;
        logic         src_reg_is_rd;
        logic         res_from_mem;
        logic         gr_we;
        logic         mem_we;
        reg_addr_t    dest;
        word_t        imm;
        branch_kind_t br_kind;
        logic         uses_src1;
        logic         uses_src2;
        logic         ine;
    } decode_ctrl_t;

    // Same shape for execute, memory and writeback
    typedef struct packed {
        logic      valid;
        logic      gr_we;
        logic      is_load;
        reg_addr_t dest;
        word_t     result;
    } stage_fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src_reg_is_rd;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        word_t     imm;
        logic      uses_src1;
        logic      uses_src2;
        logic      ine;
        word_t     rj_value;
        word_t     rkd_value;
        word_t     pc;
    } ds_to_es_t;

    typedef struct packed {
        logic  taken;
        logic  stall;
        word_t target;
    } br_bus_t;

endpackage

`default_nettype wire

//--- design/id_latch.sv
`timescale 1ns/10ps
`default_nettype none

module id_latch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_valid,
    input  id_pkg::fetch_bundle_t fs_bundle,
    input  logic                  es_allowin,
    input  logic                  ready_go,
    input  logic                  br_taken,
    output logic                  ds_allowin,
    output logic                  ds_valid,
    output id_pkg::fetch_bundle_t ds_bundle
);

    // Empty, or the held instruction moves on this edge
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            // A departing taken branch drops the wrong-path fetch
            ds_valid <= fs_valid && !br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bundle <= fs_bundle;
        end
    end

    held_bundle_stable: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin |=> $stable(ds_bundle)
    );

endmodule

`default_nettype wire

//--- design/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  id_pkg::word_t        inst,
    output id_pkg::decode_ctrl_t ctrl
);

    logic [5:0]        op_hi;
    logic [3:0]        op_mid;
    logic [1:0]        op_sub;
    logic [4:0]        op_lo;
    id_pkg::reg_addr_t rd;
    logic [11:0]       i12;
    logic [19:0]       i20;
    logic              grp_3r;
    logic              inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic              inst_and, inst_or, inst_xor, inst_nor;
    logic              inst_addi_w, inst_andi, inst_ori, inst_lu12i_w;
    logic              inst_ld_w, inst_st_w;
    logic              inst_beq, inst_bne, inst_blt, inst_bge;
    logic              inst_b, inst_bl, inst_jirl;
    logic              cond_br;
    logic              known;

    assign op_hi  = inst[31:26];
    assign op_mid = inst[25:22];
    assign op_sub = inst[21:20];
    assign op_lo  = inst[19:15];
    assign rd     = inst[4:0];
    assign i12    = inst[21:10];
    assign i20    = inst[24:5];

    // Three-register ALU group
    assign grp_3r = (op_hi == id_pkg::OP_HI_ALU3R) && (op_mid == id_pkg::OP_MID_ALU3R)
                 && (op_sub == id_pkg::OP_SUB_3R);

    assign inst_add_w = grp_3r && (op_lo == id_pkg::OP_LO_ADD);
    assign inst_sub_w = grp_3r && (op_lo == id_pkg::OP_LO_SUB);
    assign inst_slt   = grp_3r && (op_lo == id_pkg::OP_LO_SLT);
    assign inst_sltu  = grp_3r && (op_lo == id_pkg::OP_LO_SLTU);
    assign inst_nor   = grp_3r && (op_lo == id_pkg::OP_LO_NOR);
    assign inst_and   = grp_3r && (op_lo == id_pkg::OP_LO_AND);
    assign inst_or    = grp_3r && (op_lo == id_pkg::OP_LO_OR);
    assign inst_xor   = grp_3r && (op_lo == id_pkg::OP_LO_XOR);

    assign inst_addi_w  = (op_hi == id_pkg::OP_HI_ALU3R) && (op_mid == id_pkg::OP_MID_ADDI);
    assign inst_andi    = (op_hi == id_pkg::OP_HI_ALU3R) && (op_mid == id_pkg::OP_MID_ANDI);
    assign inst_ori     = (op_hi == id_pkg::OP_HI_ALU3R) && (op_mid == id_pkg::OP_MID_ORI);
    assign inst_lu12i_w = (op_hi == id_pkg::OP_HI_LU12I) && !inst[25];
    assign inst_ld_w    = (op_hi == id_pkg::OP_HI_LDST) && (op_mid == id_pkg::OP_MID_LDW);
    assign inst_st_w    = (op_hi == id_pkg::OP_HI_LDST) && (op_mid == id_pkg::OP_MID_STW);

    assign inst_jirl = (op_hi == id_pkg::OP_HI_JIRL);
    assign inst_b    = (op_hi == id_pkg::OP_HI_B);
    assign inst_bl   = (op_hi == id_pkg::OP_HI_BL);
    assign inst_beq  = (op_hi == id_pkg::OP_HI_BEQ);
    assign inst_bne  = (op_hi == id_pkg::OP_HI_BNE);
    assign inst_blt  = (op_hi == id_pkg::OP_HI_BLT);
    assign inst_bge  = (op_hi == id_pkg::OP_HI_BGE);

    assign cond_br = inst_beq || inst_bne || inst_blt || inst_bge;
    assign known   = grp_3r && (inst_add_w || inst_sub_w || inst_slt || inst_sltu
                             || inst_nor || inst_and || inst_or || inst_xor)
                  || inst_addi_w || inst_andi || inst_ori || inst_lu12i_w
                  || inst_ld_w || inst_st_w || cond_br || inst_b || inst_bl || inst_jirl;

    // Address generation and link values go through the adder
    assign ctrl.alu_op[id_pkg::ALU_ADD]   = inst_add_w || inst_addi_w || inst_ld_w
                                         || inst_st_w || inst_jirl || inst_bl;
    assign ctrl.alu_op[id_pkg::ALU_SUB]   = inst_sub_w;
    assign ctrl.alu_op[id_pkg::ALU_SLT]   = inst_slt;
    assign ctrl.alu_op[id_pkg::ALU_SLTU]  = inst_sltu;
    assign ctrl.alu_op[id_pkg::ALU_AND]   = inst_and || inst_andi;
    assign ctrl.alu_op[id_pkg::ALU_NOR]   = inst_nor;
    assign ctrl.alu_op[id_pkg::ALU_OR]    = inst_or || inst_ori;
    assign ctrl.alu_op[id_pkg::ALU_XOR]   = inst_xor;
    assign ctrl.alu_op[id_pkg::ALU_LUI]   = inst_lu12i_w;
    assign ctrl.alu_op[id_pkg::ALU_SPARE] = 1'b0;

    assign ctrl.src1_is_pc    = inst_jirl || inst_bl;
    assign ctrl.src2_is_imm   = inst_addi_w || inst_andi || inst_ori || inst_lu12i_w
                             || inst_ld_w || inst_st_w || inst_jirl || inst_bl;
    assign ctrl.src_reg_is_rd = inst_st_w || cond_br;
    assign ctrl.res_from_mem  = inst_ld_w;
    assign ctrl.gr_we         = known && !inst_st_w && !cond_br && !inst_b;
    assign ctrl.mem_we        = inst_st_w;
    assign ctrl.dest          = inst_bl ? id_pkg::RA_REG : rd;

    // Logical immediates are zero-extended
    assign ctrl.imm = (inst_bl || inst_jirl) ? 32'd4 :
                      inst_lu12i_w           ? {i20, 12'b0} :
                      (inst_andi || inst_ori) ? {20'b0, i12} :
                                               {{20{i12[11]}}, i12};

    assign ctrl.br_kind = inst_beq              ? id_pkg::BR_BEQ :
                          inst_bne              ? id_pkg::BR_BNE :
                          inst_blt              ? id_pkg::BR_BLT :
                          inst_bge              ? id_pkg::BR_BGE :
                          (inst_b || inst_bl)   ? id_pkg::BR_UNCOND :
                          inst_jirl             ? id_pkg::BR_JIRL :
                                                  id_pkg::BR_NONE;

    assign ctrl.uses_src1 = known && !inst_b && !inst_bl && !inst_lu12i_w;
    assign ctrl.uses_src2 = grp_3r || inst_st_w || cond_br;
    assign ctrl.ine       = !known;

    always_comb begin
        alu_sel_onehot: assert ($onehot0(ctrl.alu_op));
    end

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::rf_write_t wr
);

    id_pkg::word_t regs [32];

    // Entry 0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Same-cycle write is not visible here
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- design/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass (
    input  logic                 ds_valid,
    input  id_pkg::decode_ctrl_t ctrl,
    input  id_pkg::reg_addr_t    raddr1,
    input  id_pkg::reg_addr_t    raddr2,
    input  id_pkg::word_t        rdata1,
    input  id_pkg::word_t        rdata2,
    input  id_pkg::stage_fwd_t   es_fwd,
    input  id_pkg::stage_fwd_t   ms_fwd,
    input  id_pkg::stage_fwd_t   ws_fwd,
    output id_pkg::word_t        rj_value,
    output id_pkg::word_t        rkd_value,
    output logic                 ready_go,
    output logic                 load_stall
);

    id_pkg::reg_addr_t src1;
    id_pkg::reg_addr_t src2;
    logic              es_hit1, ms_hit1, ws_hit1;
    logic              es_hit2, ms_hit2, ws_hit2;

    function automatic logic raw_hit(input id_pkg::reg_addr_t src,
                                     input id_pkg::stage_fwd_t fwd);
        raw_hit = fwd.valid && fwd.gr_we && (src != '0) && (fwd.dest == src);
    endfunction

    // Unused sources map to r0 and never match
    assign src1 = ctrl.uses_src1 ? raddr1 : '0;
    assign src2 = ctrl.uses_src2 ? raddr2 : '0;

    assign es_hit1 = raw_hit(src1, es_fwd);
    assign ms_hit1 = raw_hit(src1, ms_fwd);
    assign ws_hit1 = raw_hit(src1, ws_fwd);
    assign es_hit2 = raw_hit(src2, es_fwd);
    assign ms_hit2 = raw_hit(src2, ms_fwd);
    assign ws_hit2 = raw_hit(src2, ws_fwd);

    // Youngest producer wins
    assign rj_value  = es_hit1 ? es_fwd.result :
                       ms_hit1 ? ms_fwd.result :
                       ws_hit1 ? ws_fwd.result : rdata1;
    assign rkd_value = es_hit2 ? es_fwd.result :
                       ms_hit2 ? ms_fwd.result :
                       ws_hit2 ? ws_fwd.result : rdata2;

    // Load data is not ready until memory
    assign load_stall = ds_valid && es_fwd.is_load && (es_hit1 || es_hit2);
    assign ready_go   = !load_stall;

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  logic                 ds_valid,
    input  logic                 ready_go,
    input  id_pkg::branch_kind_t kind,
    input  id_pkg::word_t        rj_value,
    input  id_pkg::word_t        rkd_value,
    input  id_pkg::word_t        pc,
    input  id_pkg::word_t        imm_offs,
    input  logic                 load_stall,
    output id_pkg::br_bus_t      br
);

    id_pkg::word_t diff;
    logic          overflow;
    logic          rj_eq;
    logic          rj_lt;
    logic          cond;
    id_pkg::word_t offs16;
    id_pkg::word_t offs26;

    // rj - rkd, signed order from the sign bit and the overflow
    assign diff     = rj_value - rkd_value;
    assign overflow = (rj_value[31] ^ rkd_value[31]) & (rj_value[31] ^ diff[31]);
    assign rj_eq    = (diff == '0);
    assign rj_lt    = diff[31] ^ overflow;

    always_comb begin
        case (kind)
            id_pkg::BR_BEQ:    cond = rj_eq;
            id_pkg::BR_BNE:    cond = !rj_eq;
            id_pkg::BR_BLT:    cond = rj_lt;
            id_pkg::BR_BGE:    cond = !rj_lt;
            id_pkg::BR_UNCOND: cond = 1'b1;
            id_pkg::BR_JIRL:   cond = 1'b1;
            default:           cond = 1'b0;
        endcase
    end

    // Offsets are word aligned
    assign offs16 = {{14{imm_offs[25]}}, imm_offs[25:10], 2'b00};
    assign offs26 = {{4{imm_offs[9]}}, imm_offs[9:0], imm_offs[25:10], 2'b00};

    assign br.taken  = ds_valid && ready_go && cond;
    assign br.stall  = load_stall && (kind != id_pkg::BR_NONE);
    assign br.target = (kind == id_pkg::BR_JIRL)   ? rj_value + offs16 :
                       (kind == id_pkg::BR_UNCOND) ? pc + offs26 :
                                                     pc + offs16;

endmodule

`default_nettype wire

//--- design/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_valid,
    input  id_pkg::fetch_bundle_t fs_bundle,
    output logic                  ds_allowin,
    input  logic                  es_allowin,
    output logic                  ds_to_es_valid,
    output id_pkg::ds_to_es_t     ds_to_es,
    input  id_pkg::stage_fwd_t    es_fwd,
    input  id_pkg::stage_fwd_t    ms_fwd,
    input  id_pkg::stage_fwd_t    ws_fwd,
    input  id_pkg::rf_write_t     rf_wr,
    output id_pkg::br_bus_t       br
);

    logic                  ds_valid;
    logic                  ready_go;
    logic                  load_stall;
    id_pkg::fetch_bundle_t ds_bundle;
    id_pkg::decode_ctrl_t  ctrl;
    id_pkg::reg_addr_t     raddr1;
    id_pkg::reg_addr_t     raddr2;
    id_pkg::word_t         rdata1;
    id_pkg::word_t         rdata2;
    id_pkg::word_t         rj_value;
    id_pkg::word_t         rkd_value;

    id_latch u_latch (
        .clk        (clk),
        .reset      (reset),
        .fs_valid   (fs_valid),
        .fs_bundle  (fs_bundle),
        .es_allowin (es_allowin),
        .ready_go   (ready_go),
        .br_taken   (br.taken),
        .ds_allowin (ds_allowin),
        .ds_valid   (ds_valid),
        .ds_bundle  (ds_bundle)
    );

    inst_decoder u_decoder (
        .inst (ds_bundle.inst),
        .ctrl (ctrl)
    );

    // Stores and compare branches read rd as the second source
    assign raddr1 = ds_bundle.inst[9:5];
    assign raddr2 = ctrl.src_reg_is_rd ? ds_bundle.inst[4:0] : ds_bundle.inst[14:10];

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (rf_wr)
    );

    operand_bypass u_bypass (
        .ds_valid   (ds_valid),
        .ctrl       (ctrl),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .ready_go   (ready_go),
        .load_stall (load_stall)
    );

    branch_unit u_branch (
        .ds_valid   (ds_valid),
        .ready_go   (ready_go),
        .kind       (ctrl.br_kind),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .pc         (ds_bundle.pc),
        .imm_offs   (ds_bundle.inst),
        .load_stall (load_stall),
        .br         (br)
    );

    assign ds_to_es_valid = ds_valid && ready_go;

    assign ds_to_es.alu_op        = ctrl.alu_op;
    assign ds_to_es.src1_is_pc    = ctrl.src1_is_pc;
    assign ds_to_es.src2_is_imm   = ctrl.src2_is_imm;
    assign ds_to_es.src_reg_is_rd = ctrl.src_reg_is_rd;
    assign ds_to_es.res_from_mem  = ctrl.res_from_mem;
    assign ds_to_es.gr_we         = ctrl.gr_we;
    assign ds_to_es.mem_we        = ctrl.mem_we;
    assign ds_to_es.dest          = ctrl.dest;
    assign ds_to_es.imm           = ctrl.imm;
    assign ds_to_es.uses_src1     = ctrl.uses_src1;
    assign ds_to_es.uses_src2     = ctrl.uses_src2;
    assign ds_to_es.ine           = ctrl.ine;
    assign ds_to_es.rj_value      = rj_value;
    assign ds_to_es.rkd_value     = rkd_value;
    assign ds_to_es.pc            = ds_bundle.pc;

    // A branch waiting on a load neither redirects nor issues
    stalled_branch_quiet: assert property (
        @(posedge clk) disable iff (reset)
        br.stall |-> !br.taken && !ds_to_es_valid
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held for three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage;

    logic                  clk;
    logic                  reset;
    logic                  fs_valid;
    id_pkg::fetch_bundle_t fs_bundle;
    logic                  ds_allowin;
    logic                  es_allowin;
    logic                  ds_to_es_valid;
    id_pkg::ds_to_es_t     ds_to_es;
    id_pkg::stage_fwd_t    es_fwd;
    id_pkg::stage_fwd_t    ms_fwd;
    id_pkg::stage_fwd_t    ws_fwd;
    id_pkg::rf_write_t     rf_wr;
    id_pkg::br_bus_t       br;

    int           errors = 0;
    int           checks = 0;
    int           seed = 32'h64a86375;
    logic [31:0]  reg_a;
    logic [31:0]  reg_b;
    logic [31:0]  pc_now = 32'h1c00_0000;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    id_stage u_dut (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fs_bundle      (fs_bundle),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .rf_wr          (rf_wr),
        .br             (br)
    );

    // Wrong-path instruction must not issue after a redirect
    taken_drops_next: assert property (
        @(posedge clk) disable iff (reset)
        br.taken && !(fs_valid && ds_allowin) |=> !ds_to_es_valid
    ) else begin
        errors++;
        $display("valid output seen on the cycle after a taken branch");
    end

    // Back-pressure keeps the outgoing instruction in place
    held_output_stable: assert property (
        @(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es.pc) && $stable(ds_to_es.dest)
    ) else begin
        errors++;
        $display("outgoing instruction changed while execute held it back");
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic id_pkg::stage_fwd_t make_fwd(input logic valid, input logic is_load,
                                                    input logic [4:0] dest,
                                                    input logic [31:0] result);
        id_pkg::stage_fwd_t fwd;
        fwd.valid   = valid;
        fwd.gr_we   = 1'b1;
        fwd.is_load = is_load;
        fwd.dest    = dest;
        fwd.result  = result;
        return fwd;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [4:0] lo, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        enc_3r = {id_pkg::OP_HI_ALU3R, id_pkg::OP_MID_ALU3R, id_pkg::OP_SUB_3R, lo, rk, rj, rd};
    endfunction

    // Layout of jirl and the 16-bit offset branches
    function automatic logic [31:0] enc_ri(input logic [5:0] op, input logic [15:0] imm,
                                           input logic [4:0] rj, input logic [4:0] rd);
        enc_ri = {op, imm, rj, rd};
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        rf_wr.we   <= 1'b1;
        rf_wr.addr <= addr;
        rf_wr.data <= data;
        @(posedge clk);
        rf_wr.we   <= 1'b0;
    endtask

    task automatic send(input logic [31:0] inst);
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_allowin && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!ds_allowin) begin
            errors++;
            $display("decode stage never accepted a new instruction");
        end
        pc_now = pc_now + 32'd4;
        @(posedge clk);
        fs_valid       <= 1'b1;
        fs_bundle.pc   <= pc_now;
        fs_bundle.inst <= inst;
        @(posedge clk);
        fs_valid <= 1'b0;
    endtask

    task automatic wait_out();
        int n;
        n = 0;
        @(negedge clk);
        while (!ds_to_es_valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!ds_to_es_valid) begin
            errors++;
            $display("decode output never became valid");
        end
    endtask

    task automatic decode_case(input logic [31:0] inst, input int alu_idx, input logic gr,
                               input logic mem, input logic [31:0] imm, input logic chk_imm);
        send(inst);
        wait_out();
        check_val("alu_op", 32'(ds_to_es.alu_op), 32'(10'b1 << alu_idx));
        check_val("gr_we", 32'(ds_to_es.gr_we), 32'(gr));
        check_val("mem_we", 32'(ds_to_es.mem_we), 32'(mem));
        check_val("dest", 32'(ds_to_es.dest), 32'(inst[4:0]));
        check_val("pc", ds_to_es.pc, pc_now);
        check_val("src2_is_imm", 32'(ds_to_es.src2_is_imm), 32'(chk_imm));
        if (chk_imm) begin
            check_val("imm", ds_to_es.imm, imm);
        end
    endtask

    task automatic branch_case(input logic [5:0] hi, input logic [15:0] offs);
        logic taken_exp;
        reg_a = $random(seed);
        reg_b = (hi == id_pkg::OP_HI_BEQ && offs[0]) ? reg_a : $random(seed);
        write_reg(5'd5, reg_a);
        write_reg(5'd6, reg_b);
        case (hi)
            id_pkg::OP_HI_BEQ: taken_exp = (reg_a == reg_b);
            id_pkg::OP_HI_BNE: taken_exp = (reg_a != reg_b);
            id_pkg::OP_HI_BLT: taken_exp = ($signed(reg_a) < $signed(reg_b));
            default:           taken_exp = ($signed(reg_a) >= $signed(reg_b));
        endcase
        send(enc_ri(hi, offs, 5'd5, 5'd6));
        wait_out();
        check_val("br.taken", 32'(br.taken), 32'(taken_exp));
        check_val("br.target", br.target, pc_now + {{14{offs[15]}}, offs, 2'b00});
    endtask

    initial begin
        logic [11:0] i12;
        logic [19:0] i20;
        logic [25:0] o26;
        logic [15:0] o16;
        logic [31:0] res_a;
        logic [31:0] res_b;
        int          n;
        fs_valid   = 1'b0;
        fs_bundle  = '0;
        es_allowin = 1'b1;
        es_fwd     = '0;
        ms_fwd     = '0;
        ws_fwd     = '0;
        rf_wr      = '0;
        n          = 0;
        @(negedge clk);
        while (reset && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (reset) begin
            errors++;
            $display("reset was never released");
        end
        check_val("ds_allowin", 32'(ds_allowin), 32'd1);
        check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
        check_val("br.taken", 32'(br.taken), 32'd0);

        // Register file write, read back, r0 ignores writes
        reg_a = $random(seed);
        reg_b = $random(seed);
        write_reg(5'd5, reg_a);
        write_reg(5'd6, reg_b);
        write_reg(5'd0, 32'hdead_beef);
        repeat (3) @(posedge clk);
        send(enc_3r(id_pkg::OP_LO_ADD, 5'd7, 5'd5, 5'd6));
        wait_out();
        check_val("rj_value", ds_to_es.rj_value, reg_a);
        check_val("rkd_value", ds_to_es.rkd_value, reg_b);
        send(enc_3r(id_pkg::OP_LO_ADD, 5'd7, 5'd0, 5'd6));
        wait_out();
        check_val("rj_value r0", ds_to_es.rj_value, 32'd0);

        // Decode of ALU, immediate and memory instructions
        i12 = 12'($random(seed));
        i20 = 20'($random(seed));
        decode_case(enc_3r(id_pkg::OP_LO_ADD, 5'd9, 5'd5, 5'd6), 0, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case(enc_3r(id_pkg::OP_LO_SUB, 5'd9, 5'd5, 5'd6), 1, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case(enc_3r(id_pkg::OP_LO_SLT, 5'd9, 5'd5, 5'd6), 2, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case(enc_3r(id_pkg::OP_LO_SLTU, 5'd9, 5'd5, 5'd6), 3, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case(enc_3r(id_pkg::OP_LO_AND, 5'd9, 5'd5, 5'd6), 4, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case(enc_3r(id_pkg::OP_LO_NOR, 5'd9, 5'd5, 5'd6), 5, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case(enc_3r(id_pkg::OP_LO_OR, 5'd9, 5'd5, 5'd6), 6, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case(enc_3r(id_pkg::OP_LO_XOR, 5'd9, 5'd5, 5'd6), 7, 1'b1, 1'b0, 32'd0, 1'b0);
        decode_case({id_pkg::OP_HI_ALU3R, id_pkg::OP_MID_ADDI, i12, 5'd5, 5'd9},
                    0, 1'b1, 1'b0, {{20{i12[11]}}, i12}, 1'b1);
        decode_case({id_pkg::OP_HI_ALU3R, id_pkg::OP_MID_ANDI, i12, 5'd5, 5'd9},
                    4, 1'b1, 1'b0, {20'd0, i12}, 1'b1);
        decode_case({id_pkg::OP_HI_ALU3R, id_pkg::OP_MID_ORI, i12, 5'd5, 5'd9},
                    6, 1'b1, 1'b0, {20'd0, i12}, 1'b1);
        decode_case({id_pkg::OP_HI_LU12I, 1'b0, i20, 5'd9}, 8, 1'b1, 1'b0, {i20, 12'd0}, 1'b1);
        check_val("lu12i uses_src1", 32'(ds_to_es.uses_src1), 32'd0);
        check_val("lu12i uses_src2", 32'(ds_to_es.uses_src2), 32'd0);
        decode_case({id_pkg::OP_HI_LDST, id_pkg::OP_MID_LDW, i12, 5'd5, 5'd9},
                    0, 1'b1, 1'b0, {{20{i12[11]}}, i12}, 1'b1);
        check_val("ld res_from_mem", 32'(ds_to_es.res_from_mem), 32'd1);
        decode_case({id_pkg::OP_HI_LDST, id_pkg::OP_MID_STW, i12, 5'd5, 5'd9},
                    0, 1'b0, 1'b1, {{20{i12[11]}}, i12}, 1'b1);
        check_val("st res_from_mem", 32'(ds_to_es.res_from_mem), 32'd0);
        check_val("st src_reg_is_rd", 32'(ds_to_es.src_reg_is_rd), 32'd1);
        check_val("st uses_src2", 32'(ds_to_es.uses_src2), 32'd1);

        // Forwarding priority while execute holds the instruction
        res_a = $random(seed);
        res_b = $random(seed);
        @(posedge clk);
        es_allowin <= 1'b0;
        es_fwd     <= make_fwd(1'b1, 1'b0, 5'd5, res_a);
        ms_fwd     <= make_fwd(1'b1, 1'b0, 5'd5, res_b);
        ws_fwd     <= make_fwd(1'b1, 1'b0, 5'd5, ~res_b);
        send(enc_3r(id_pkg::OP_LO_ADD, 5'd7, 5'd5, 5'd6));
        wait_out();
        check_val("rj_value es", ds_to_es.rj_value, res_a);
        @(posedge clk);
        es_fwd <= '0;
        @(negedge clk);
        check_val("rj_value ms", ds_to_es.rj_value, res_b);
        check_val("ds_to_es_valid held", 32'(ds_to_es_valid), 32'd1);
        @(posedge clk);
        es_allowin <= 1'b1;
        ms_fwd     <= '0;
        ws_fwd     <= '0;

        // Load-use stall until execute moves on
        @(posedge clk);
        es_fwd <= make_fwd(1'b1, 1'b1, 5'd6, res_a);
        send(enc_3r(id_pkg::OP_LO_ADD, 5'd7, 5'd5, 5'd6));
        repeat (2) begin
            @(negedge clk);
            check_val("ds_to_es_valid stall", 32'(ds_to_es_valid), 32'd0);
            check_val("ds_allowin stall", 32'(ds_allowin), 32'd0);
        end
        @(posedge clk);
        es_fwd <= '0;
        wait_out();
        check_val("rkd_value after stall", ds_to_es.rkd_value, reg_b);

        // A branch behind the same load waits and does not redirect
        @(posedge clk);
        es_fwd <= make_fwd(1'b1, 1'b1, 5'd6, res_a);
        send(enc_ri(id_pkg::OP_HI_BEQ, 16'h0010, 5'd5, 5'd6));
        @(negedge clk);
        check_val("br.stall", 32'(br.stall), 32'd1);
        check_val("br.taken stall", 32'(br.taken), 32'd0);
        @(posedge clk);
        es_fwd <= '0;
        wait_out();
        check_val("br.stall released", 32'(br.stall), 32'd0);

        // Conditional branches on random operands
        for (int k = 0; k < 8; k++) begin
            o16 = 16'($random(seed));
            branch_case(id_pkg::OP_HI_BEQ + 6'(k % 4), o16);
        end

        // b, bl and jirl targets
        o26 = 26'($random(seed));
        send({id_pkg::OP_HI_B, o26[15:0], o26[25:16]});
        wait_out();
        check_val("b target", br.target, pc_now + {{4{o26[25]}}, o26, 2'b00});
        check_val("b taken", 32'(br.taken), 32'd1);
        send({id_pkg::OP_HI_BL, o26[15:0], o26[25:16]});
        wait_out();
        check_val("bl target", br.target, pc_now + {{4{o26[25]}}, o26, 2'b00});
        check_val("bl dest", 32'(ds_to_es.dest), 32'd1);
        check_val("bl gr_we", 32'(ds_to_es.gr_we), 32'd1);
        check_val("bl src1_is_pc", 32'(ds_to_es.src1_is_pc), 32'd1);
        o16 = 16'($random(seed));
        send(enc_ri(id_pkg::OP_HI_JIRL, o16, 5'd5, 5'd3));
        wait_out();
        check_val("jirl target", br.target, reg_a + {{14{o16[15]}}, o16, 2'b00});
        check_val("jirl imm", ds_to_es.imm, 32'd4);

        // Encoding outside the kept set
        send(32'hffff_ffff);
        wait_out();
        check_val("ine", 32'(ds_to_es.ine), 32'd1);
        check_val("gr_we ine", 32'(ds_to_es.gr_we), 32'd0);
        check_val("mem_we ine", 32'(ds_to_es.mem_we), 32'd0);

        repeat (2) @(posedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/id_pkg.sv
design/id_latch.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
verif/tb_clock.sv
verif/tb_id_stage.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_id_stage -f files.f -o sim_id_stage &&
./obj_dir/sim_id_stage | grep -F "Simulation finished: PASS" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
